//--- lane_link_pkg.sv
`default_nettype none

package lane_link_pkg;

  // ##########################################################
  // link geometry
  // ##########################################################

  localparam int LANE_COUNT = 4;   // parallel byte lanes
  localparam int LANE_BITS  = 8;   // bits per lane, also beats per frame
  localparam int SLOT_W     = 3;   // slot index width

  // receive buffer, one link credit per entry
  localparam int FIFO_DEPTH = 4;
  localparam int CREDIT_W   = 3;   // holds 0..FIFO_DEPTH

  // ##########################################################
  // payload types
  // ##########################################################

  // lane k sits at bits [8k+7:8k] of the packed word
  typedef struct packed {
    logic [LANE_BITS-1:0] lane3;
    logic [LANE_BITS-1:0] lane2;
    logic [LANE_BITS-1:0] lane1;
    logic [LANE_BITS-1:0] lane0;
  } lane_word_t;

  // one clock of the serial link
  typedef struct packed {
    logic                  valid;
    logic                  last;   // slot 7 of the frame
    logic [LANE_COUNT-1:0] bits;   // bit k belongs to lane k
  } lane_beat_t;

  // ##########################################################
  // serializer control
  // ##########################################################

  typedef enum logic {
    SER_IDLE  = 1'b0,
    SER_SHIFT = 1'b1
  } ser_state_e;

endpackage

`default_nettype wire

//--- bit_slot_ctr.sv
`default_nettype none

module bit_slot_ctr
  import lane_link_pkg::*;
(
  input  wire               clk_2mhz,
  input  wire               arst_n,
  input  wire               slot_run,
  output logic [SLOT_W-1:0] slot,
  output logic              slot_last
);

  logic running;   // inside a frame, past its load cycle

  // load cycle keeps slot at 0, so slot 0 lands in the next cycle
  always_ff @(posedge clk_2mhz or negedge arst_n) begin
    if (!arst_n) begin
      slot    <= '0;
      running <= 1'b0;
    end else if (!slot_run) begin
      slot    <= '0;
      running <= 1'b0;
    end else if (!running) begin
      slot    <= '0;
      running <= 1'b1;
    end else if (slot_last) begin
      slot    <= '0;   // back-to-back frame
    end else begin
      slot    <= slot + 1'b1;
    end
  end

  assign slot_last = (slot == SLOT_W'(LANE_BITS - 1));

endmodule

`default_nettype wire

//--- lane_serializer.sv
`default_nettype none

module lane_serializer
  import lane_link_pkg::*;
(
  input  wire               clk_2mhz,
  input  wire               arst_n,
  input  wire               in_valid,
  input  wire lane_word_t   in_word,
  input  wire               link_credit,
  input  wire  [SLOT_W-1:0] slot,
  input  wire               slot_last,
  output logic              in_credit,
  output logic              slot_run,
  output lane_beat_t        beat
);

  lane_word_t          hold_word;
  logic                hold_full;
  lane_word_t          shift_word;
  logic [CREDIT_W-1:0] credit_cnt;
  ser_state_e          state;
  logic [1:0]          boot_q;
  logic                start;
  logic                init_credit;

  // ##########################################################
  // frame start and credits
  // ##########################################################

  // new frame needs a word, a buffer credit, and a free shifter
  assign start = hold_full && (credit_cnt != '0) &&
                 ((state == SER_IDLE) || slot_last);

  assign init_credit = boot_q[0] && !boot_q[1];   // single pulse after reset
  assign in_credit   = start || init_credit;
  assign slot_run    = start || ((state == SER_SHIFT) && !slot_last);

  always_ff @(posedge clk_2mhz or negedge arst_n) begin
    if (!arst_n) begin
      boot_q <= '0;
    end else begin
      boot_q <= {boot_q[0], 1'b1};
    end
  end

  always_ff @(posedge clk_2mhz or negedge arst_n) begin
    if (!arst_n) begin
      credit_cnt <= CREDIT_W'(FIFO_DEPTH);
    end else begin
      case ({start, link_credit})
        2'b10:   credit_cnt <= credit_cnt - 1'b1;
        2'b01:   credit_cnt <= credit_cnt + 1'b1;
        default: credit_cnt <= credit_cnt;   // none, or spend and refill
      endcase
    end
  end

  // ##########################################################
  // holding register, shifter, state
  // ##########################################################

  always_ff @(posedge clk_2mhz or negedge arst_n) begin
    if (!arst_n) begin
      hold_full <= 1'b0;
    end else if (in_valid) begin
      hold_full <= 1'b1;
    end else if (start) begin
      hold_full <= 1'b0;
    end
  end

  always_ff @(posedge clk_2mhz) begin
    if (in_valid) hold_word <= in_word;
    if (start) shift_word <= hold_word;
  end

  always_ff @(posedge clk_2mhz or negedge arst_n) begin
    if (!arst_n) begin
      state <= SER_IDLE;
    end else begin
      case (state)
        SER_IDLE:  if (start) state <= SER_SHIFT;
        SER_SHIFT: if (slot_last && !start) state <= SER_IDLE;
        default:   state <= SER_IDLE;
      endcase
    end
  end

  // lsb first, one bit of every lane per slot
  always_comb begin
    beat = '0;
    if (state == SER_SHIFT) begin
      beat.valid = 1'b1;
      beat.last  = slot_last;
      for (int k = 0; k < LANE_COUNT; k++) begin
        beat.bits[k] = shift_word[k*LANE_BITS + int'(slot)];
      end
    end
  end

  a_no_input_overrun: assert property (@(posedge clk_2mhz) disable iff (!arst_n)
    in_valid |-> !hold_full);

  a_credit_bound: assert property (@(posedge clk_2mhz) disable iff (!arst_n)
    credit_cnt <= CREDIT_W'(FIFO_DEPTH));

endmodule

`default_nettype wire

//--- lane_deserializer.sv
`default_nettype none

module lane_deserializer
  import lane_link_pkg::*;
(
  input  wire              clk_2mhz,
  input  wire              arst_n,
  input  wire lane_beat_t  beat,
  input  wire [SLOT_W-1:0] slot,
  output logic             push,
  output lane_word_t       push_word
);

  lane_word_t collect_word;
  lane_word_t next_word;

  // ##########################################################
  // beat assembly
  // ##########################################################

  // drop this beat's bits into position slot of each lane
  always_comb begin
    next_word = collect_word;
    for (int k = 0; k < LANE_COUNT; k++) begin
      next_word[k*LANE_BITS + int'(slot)] = beat.bits[k];
    end
  end

  always_ff @(posedge clk_2mhz) begin
    if (beat.valid) begin
      collect_word <= next_word;
    end
    if (beat.valid && beat.last) begin
      push_word <= next_word;   // includes slot 7 bits
    end
  end

  // push trails the last beat by one cycle
  always_ff @(posedge clk_2mhz or negedge arst_n) begin
    if (!arst_n) begin
      push <= 1'b0;
    end else begin
      push <= beat.valid && beat.last;
    end
  end

  // ##########################################################
  // link checks
  // ##########################################################

  a_last_at_slot7: assert property (@(posedge clk_2mhz) disable iff (!arst_n)
    (beat.valid && beat.last) |-> (slot == SLOT_W'(LANE_BITS - 1)));

  // frames never pause, the receiver has no stall
  a_frame_unbroken: assert property (@(posedge clk_2mhz) disable iff (!arst_n)
    (beat.valid && !beat.last) |=> beat.valid);

endmodule

`default_nettype wire

//--- rx_word_fifo.sv
`default_nettype none

module rx_word_fifo
  import lane_link_pkg::*;
(
  input  wire             clk_2mhz,
  input  wire             arst_n,
  input  wire             push,
  input  wire lane_word_t push_word,
  input  wire             out_pop,
  output logic            out_valid,
  output lane_word_t      out_word,
  output logic            link_credit
);

  lane_word_t                        mem [FIFO_DEPTH];
  logic [$clog2(FIFO_DEPTH)-1:0]     wr_ptr;   // depth is a power of two
  logic [$clog2(FIFO_DEPTH)-1:0]     rd_ptr;
  logic [$clog2(FIFO_DEPTH + 1)-1:0] count;
  logic                              pop;

  assign pop         = out_pop && out_valid;   // pop on empty ignored
  assign out_valid   = (count != '0);
  assign out_word    = mem[rd_ptr];
  assign link_credit = pop;

  // ##########################################################
  // storage and pointers
  // ##########################################################

  always_ff @(posedge clk_2mhz) begin
    if (push) mem[wr_ptr] <= push_word;
  end

  always_ff @(posedge clk_2mhz or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;
      if (pop) rd_ptr <= rd_ptr + 1'b1;
    end
  end

  always_ff @(posedge clk_2mhz or negedge arst_n) begin
    if (!arst_n) begin
      count <= '0;
    end else begin
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // serializer credits keep the buffer from overflowing
  a_no_overflow: assert property (@(posedge clk_2mhz) disable iff (!arst_n)
    push |-> (int'(count) < FIFO_DEPTH));

endmodule

`default_nettype wire

//--- lane_link_top.sv
`default_nettype none

module lane_link_top
  import lane_link_pkg::*;
(
  input  wire             clk_2mhz,
  input  wire             arst_n,
  input  wire             in_valid,
  input  wire lane_word_t in_word,
  input  wire             out_pop,
  output logic            in_credit,
  output logic            out_valid,
  output lane_word_t      out_word
);

  logic [SLOT_W-1:0] slot;
  logic              slot_last;
  logic              slot_run;
  lane_beat_t        beat;        // serial link
  logic              push;
  lane_word_t        push_word;
  logic              link_credit; // buffer back to serializer

  bit_slot_ctr u_bit_slot_ctr (
    .clk_2mhz  (clk_2mhz),
    .arst_n    (arst_n),
    .slot_run  (slot_run),
    .slot      (slot),
    .slot_last (slot_last)
  );

  lane_serializer u_lane_serializer (
    .clk_2mhz    (clk_2mhz),
    .arst_n      (arst_n),
    .in_valid    (in_valid),
    .in_word     (in_word),
    .link_credit (link_credit),
    .slot        (slot),
    .slot_last   (slot_last),
    .in_credit   (in_credit),
    .slot_run    (slot_run),
    .beat        (beat)
  );

  lane_deserializer u_lane_deserializer (
    .clk_2mhz  (clk_2mhz),
    .arst_n    (arst_n),
    .beat      (beat),
    .slot      (slot),
    .push      (push),
    .push_word (push_word)
  );

  rx_word_fifo u_rx_word_fifo (
    .clk_2mhz    (clk_2mhz),
    .arst_n      (arst_n),
    .push        (push),
    .push_word   (push_word),
    .out_pop     (out_pop),
    .out_valid   (out_valid),
    .out_word    (out_word),
    .link_credit (link_credit)
  );

endmodule

`default_nettype wire

//--- tb_lane_link.sv
`default_nettype none

module tb_lane_link
  import lane_link_pkg::*;
();

  localparam int STALL_LIMIT = 200;   // cycles without send, pop or credit
  localparam int LATENCY     = 11;

  logic       clk_2mhz;
  logic       arst_n;
  logic       in_valid;
  lane_word_t in_word;
  logic       out_pop;
  logic       in_credit;
  logic       out_valid;
  lane_word_t out_word;

  // stimulus table, one entry per word
  string      row_name [$];
  lane_word_t row_word [$];
  int         row_idle [$];   // idle cycles before sending
  int         row_hold [$];   // cycles out_valid waits before the pop
  bit         row_lat  [$];   // check end-to-end latency

  int         ref_q [$];      // rows in flight, oldest first
  int         sent_at [$];

  lane_link_top u_lane_link_top (
    .clk_2mhz  (clk_2mhz),
    .arst_n    (arst_n),
    .in_valid  (in_valid),
    .in_word   (in_word),
    .out_pop   (out_pop),
    .in_credit (in_credit),
    .out_valid (out_valid),
    .out_word  (out_word)
  );

  initial begin
    clk_2mhz = 1'b0;
    forever #4 clk_2mhz = ~clk_2mhz;
  end

  // ##########################################################
  // helpers
  // ##########################################################

  task automatic add_row(input string name, input lane_word_t word, input int idle,
                         input int hold, input bit lat);
    row_name.push_back(name);
    row_word.push_back(word);
    row_idle.push_back(idle);
    row_hold.push_back(hold);
    row_lat.push_back(lat);
  endtask

  task automatic abort_sim();
    $display("Simulation finished: FAIL");
    $fatal(1, "testbench stopped");
  endtask

  task automatic check_word(input string name, input lane_word_t exp, input lane_word_t act);
    if (act !== exp) begin
      $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
      abort_sim();
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("[ERROR] %s: expected %b, actual %b", name, exp, act);
      abort_sim();
    end
  endtask

  // ##########################################################
  // main sequence
  // ##########################################################

  initial begin
    integer     seed;
    lane_word_t w;
    ser_state_e st;
    int         send_idx;
    int         idle_left;
    int         credits;
    int         hold_cnt;
    int         stall;
    int         max_flight;
    int         cyc;
    int         pulses;
    logic       prev_valid;
    logic       popped;

    arst_n     = 1'b0;
    in_valid   = 1'b0;
    in_word    = '0;
    out_pop    = 1'b0;
    seed       = 32'h2273a2f1;
    send_idx   = 0;
    credits    = 0;
    hold_cnt   = 0;
    stall      = 0;
    max_flight = 0;
    cyc        = 0;
    pulses     = 0;
    prev_valid = 1'b0;
    popped     = 1'b0;

    add_row("single_word", '{lane3: 8'h4d, lane2: 8'h3c, lane1: 8'h2b, lane0: 8'h1a},
            2, 0, 1'b1);
    // one set bit per lane, rotated so a lane swap or bit reversal shows
    for (int k = 0; k < LANE_BITS; k++) begin
      w.lane0 = 8'h01 << k;
      w.lane1 = 8'h01 << ((k + 1) % LANE_BITS);
      w.lane2 = 8'h01 << ((k + 2) % LANE_BITS);
      w.lane3 = 8'h01 << ((k + 3) % LANE_BITS);
      add_row($sformatf("walk_ones_%0d", k), w, 0, 0, 1'b0);
    end
    add_row("bp_hold", 32'hfeed_5a5a, 4, 60, 1'b0);   // buffer fills behind this one
    for (int i = 0; i < FIFO_DEPTH + 2; i++) begin
      w = 32'hc0de_0000 + i;
      add_row($sformatf("bp_fill_%0d", i), w, 0, 0, 1'b0);
    end
    for (int i = 0; i < 40; i++) begin
      w = $random(seed);
      add_row($sformatf("random_%0d", i), w, $unsigned($random(seed)) % 4,
              $unsigned($random(seed)) % 8, 1'b0);
    end

    repeat (3) @(posedge clk_2mhz);
    arst_n <= 1'b1;

    // after reset, one credit and no output
    for (int i = 0; i < 8; i++) begin
      @(negedge clk_2mhz);
      check_bit("reset_out_valid", 1'b0, out_valid);
      if (in_credit) pulses++;
    end
    check_bit("reset_one_credit", 1'b1, pulses == 1);
    credits   = pulses;
    idle_left = row_idle[0];

    while (send_idx < row_name.size() || ref_q.size() != 0) begin
      @(posedge clk_2mhz);
      cyc++;
      stall++;
      in_valid <= 1'b0;
      if (send_idx < row_name.size() && idle_left > 0) begin
        idle_left--;
      end else if (send_idx < row_name.size() && credits > 0) begin
        in_valid <= 1'b1;
        in_word  <= row_word[send_idx];
        credits--;
        ref_q.push_back(send_idx);
        sent_at.push_back(cyc);
        send_idx++;
        stall = 0;
        if (send_idx < row_name.size()) idle_left = row_idle[send_idx];
      end
      if (ref_q.size() != 0) begin
        out_pop <= (hold_cnt >= row_hold[ref_q[0]]);
      end else begin
        out_pop <= 1'b0;
      end

      @(negedge clk_2mhz);
      if (in_credit) begin
        check_bit("credit_in_flight_bound", 1'b1, ref_q.size() <= FIFO_DEPTH);
        credits++;
        check_bit("single_input_credit", 1'b1, credits == 1);
        stall = 0;
      end
      if (prev_valid && !popped) check_bit("out_valid_held", 1'b1, out_valid);
      popped = 1'b0;
      if (ref_q.size() != 0 && row_lat[ref_q[0]]) begin
        if (cyc - sent_at[0] < LATENCY) check_bit("latency_early", 1'b0, out_valid);
        if (cyc - sent_at[0] == LATENCY) check_bit("latency_on_time", 1'b1, out_valid);
      end
      if (out_valid) begin
        if (ref_q.size() == 0) begin
          $display("out_valid went high although no word was in flight");
          abort_sim();
        end
        if (out_pop) begin
          check_word(row_name[ref_q[0]], row_word[ref_q[0]], out_word);
          void'(ref_q.pop_front());
          void'(sent_at.pop_front());
          hold_cnt = 0;
          popped   = 1'b1;
          stall    = 0;
        end else begin
          hold_cnt++;
        end
      end
      prev_valid = out_valid;
      if (ref_q.size() > max_flight) max_flight = ref_q.size();

      if (stall > STALL_LIMIT) begin
        st = u_lane_link_top.u_lane_serializer.state;
        if (send_idx < row_name.size() && credits == 0) begin
          $display("timeout: no in_credit for %0d cycles, serializer in %s",
                   STALL_LIMIT, st.name());
        end else begin
          $display("timeout: no word on out_valid for %0d cycles, %0d words outstanding",
                   STALL_LIMIT, ref_q.size());
        end
        abort_sim();
      end
    end

    @(posedge clk_2mhz);
    out_pop <= 1'b0;
    @(negedge clk_2mhz);
    check_bit("drained_out_valid", 1'b0, out_valid);
    check_bit("backpressure_reached", 1'b1, max_flight == FIFO_DEPTH + 1);

    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

`default_nettype wire

//--- src.f
lane_link_pkg.sv
bit_slot_ctr.sv
lane_serializer.sv
lane_deserializer.sv
rx_word_fifo.sv
lane_link_top.sv
tb_lane_link.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_lane_link -f src.f -o sim_lane_link

# the log decides pass or fail
./obj_dir/sim_lane_link > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation finished: PASS" sim.log; then
  exit 0
else
  exit 1
fi
